// File: verilog/ctrl_pkg.sv
package ctrl_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // interrupt id from the interrupt controller
  parameter int unsigned IRQ_ID_W = 5;
  // exception / interrupt cause as seen by the CSR file
  parameter int unsigned CAUSE_W  = 6;

  // synchronous exception cause codes
  parameter logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN = 6'h02;
  parameter logic [CAUSE_W-1:0] EXC_CAUSE_BREAKPOINT   = 6'h03;
  parameter logic [CAUSE_W-1:0] EXC_CAUSE_ECALL_MMODE  = 6'h0b;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  // main controller states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // one-cycle order from the FSM to the trap unit
  typedef enum logic [2:0] {
    ACT_NONE,
    ACT_BOOT,
    ACT_JUMP,
    ACT_TRAP,
    ACT_IRQ
  } ctrl_action_e;

  // PC mux select in the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_sel_e;

  // exception vector select, 2'b10 is left free for a load fault
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'b00,
    EXC_PC_ECALL   = 2'b01,
    EXC_PC_IRQ     = 2'b11
  } exc_pc_e;

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  // decoded instruction class, one flag per class
  typedef struct packed {
    logic is_jump;
    logic is_branch_taken;
    logic is_ecall;
    logic is_illegal;
    logic is_mret;
    logic is_ebreak;
    logic is_flush;
    logic multicycle;
  } ctrl_insn_t;

  // stall events from the pipeline
  typedef struct packed {
    logic jump_stall;
    logic branch_stall;
    logic load_stall;
  } perf_events_t;

  // request to the prefetcher
  typedef struct packed {
    logic               set;
    pc_sel_e            sel;
    exc_pc_e            exc_sel;
    logic [CAUSE_W-1:0] exc_cause;
  } pc_req_t;

  // request to the CSR file
  typedef struct packed {
    logic               save_if;
    logic               save_id;
    logic               save_cause;
    logic               restore_mret;
    logic [CAUSE_W-1:0] cause;
  } csr_req_t;

endpackage

// File: verilog/ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                 clk,
  input  logic                 rst_n,

  // core enable and decoded instruction
  input  logic                 fetch_enable_i,
  input  logic                 insn_valid_i,
  input  ctrl_pkg::ctrl_insn_t insn_i,

  // interrupt request and M-mode enable
  input  logic                 irq_req_i,
  input  logic                 m_ie_i,

  // handshake and pipeline control
  output logic                 insn_ready_o,
  output logic                 busy_o,
  output logic                 instr_req_o,
  output logic                 halt_if_o,

  // orders to the trap unit and the counters
  output ctrl_pkg::ctrl_action_e action_o,
  output logic                 capture_o,
  output logic                 irq_capture_o,
  output logic                 jump_fire_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // instruction needs a flush cycle
  logic trap_class;
  // instruction redirects the PC right away
  logic jump_class;
  // enabled interrupt waiting
  logic irq_pending;
  // valid instruction that must finish before an interrupt
  logic irq_blocked;

  ////////////////////////////////////////
  // instruction classification
  ////////////////////////////////////////

  // csr status is folded into is_flush by the decoder
  assign trap_class  = insn_i.is_ecall | insn_i.is_illegal | insn_i.is_mret |
                       insn_i.is_ebreak | insn_i.is_flush;
  assign jump_class  = insn_i.is_jump | insn_i.is_branch_taken;
  assign irq_pending = irq_req_i & m_ie_i;

  // a plain valid instruction does not block the interrupt,
  // it stays in ID (not consumed) and is decoded after IRQ_TAKEN
  assign irq_blocked = insn_valid_i & (trap_class | jump_class | insn_i.multicycle);

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb begin
    // defaults: running core, nothing ordered
    state_d       = state_q;
    action_o      = ACT_NONE;
    busy_o        = 1'b1;
    instr_req_o   = 1'b1;
    halt_if_o     = 1'b0;
    insn_ready_o  = 1'b0;
    capture_o     = 1'b0;
    irq_capture_o = 1'b0;
    jump_fire_o   = 1'b0;

    unique case (state_q)
      // wait for fetch enable after reset
      RESET: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch PC
      BOOT_SET: begin
        action_o = ACT_BOOT;
        state_d  = FIRST_FETCH;
      end

      // one cycle of halted fetch before sleep
      WAIT_SLEEP: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        state_d     = SLEEP;
      end

      // pipeline is empty here, wake on enable or any irq
      SLEEP: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        if (fetch_enable_i || irq_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        state_d = DECODE;
        // nothing is in flight yet, so an irq can go at once
        if (irq_pending) begin
          halt_if_o     = 1'b1;
          irq_capture_o = 1'b1;
          state_d       = IRQ_TAKEN;
        end
      end

      DECODE: begin
        if (irq_pending && !irq_blocked) begin
          // take the irq, hold the instruction back
          halt_if_o     = 1'b1;
          irq_capture_o = 1'b1;
          state_d       = IRQ_TAKEN;
        end else begin
          insn_ready_o = 1'b1;
          if (insn_valid_i) begin
            jump_fire_o = insn_i.is_jump;
            // jumps and branches redirect in the same cycle
            if (jump_class) begin
              action_o = ACT_JUMP;
            end else if (trap_class) begin
              capture_o = 1'b1;
              halt_if_o = 1'b1;
              state_d   = FLUSH;
            end
          end
        end
      end

      // flush cycle, the trap unit resolves the stored class
      FLUSH: begin
        action_o  = ACT_TRAP;
        halt_if_o = ~fetch_enable_i;
        if (fetch_enable_i) begin
          state_d = DECODE;
        end else begin
          state_d = WAIT_SLEEP;
        end
      end

      // jump to the irq vector and save the cause
      IRQ_TAKEN: begin
        action_o = ACT_IRQ;
        state_d  = DECODE;
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: verilog/trap_cause_gen.sv
`timescale 1ns/1ps

module trap_cause_gen (
  input  logic                          clk,
  input  logic                          rst_n,

  // order from the FSM
  input  ctrl_pkg::ctrl_action_e        action_i,

  // instruction class, stored on capture
  input  logic                          capture_i,
  input  ctrl_pkg::ctrl_insn_t          insn_i,

  // interrupt id, stored on irq capture
  input  logic                          irq_capture_i,
  input  logic [ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,

  // requests to the prefetcher and the CSR file
  output ctrl_pkg::pc_req_t             pc_req_o,
  output ctrl_pkg::csr_req_t            csr_req_o
);

  import ctrl_pkg::*;

  // class of the instruction now in the flush cycle
  ctrl_insn_t          insn_q;
  // id of the interrupt being taken
  logic [IRQ_ID_W-1:0] irq_id_q;

  ////////////////////////////////////////
  // capture registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      insn_q <= '0;
    end else if (capture_i) begin
      insn_q <= insn_i;
    end
  end

  // read only in IRQ_TAKEN, one cycle after the capture
  always_ff @(posedge clk) begin
    if (irq_capture_i) begin
      irq_id_q <= irq_id_i;
    end
  end

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  always_comb begin
    // idle value is all zero
    pc_req_o  = '0;
    csr_req_o = '0;

    unique case (action_i)
      ACT_BOOT: begin
        pc_req_o.set = 1'b1;
        pc_req_o.sel = PC_BOOT;
      end

      ACT_JUMP: begin
        pc_req_o.set = 1'b1;
        pc_req_o.sel = PC_JUMP;
      end

      ACT_IRQ: begin
        pc_req_o.set        = 1'b1;
        pc_req_o.sel        = PC_EXCEPTION;
        pc_req_o.exc_sel    = EXC_PC_IRQ;
        pc_req_o.exc_cause  = {1'b0, irq_id_q};
        // msb of the CSR cause marks an interrupt
        csr_req_o.cause      = {1'b1, irq_id_q};
        csr_req_o.save_if    = 1'b1;
        csr_req_o.save_cause = 1'b1;
      end

      ACT_TRAP: begin
        // priority ecall > illegal > mret > ebreak > flush
        if (insn_q.is_ecall) begin
          pc_req_o.set         = 1'b1;
          pc_req_o.sel         = PC_EXCEPTION;
          pc_req_o.exc_sel     = EXC_PC_ECALL;
          pc_req_o.exc_cause   = EXC_CAUSE_ECALL_MMODE;
          csr_req_o.cause      = EXC_CAUSE_ECALL_MMODE;
          csr_req_o.save_id    = 1'b1;
          csr_req_o.save_cause = 1'b1;
        end else if (insn_q.is_illegal) begin
          pc_req_o.set         = 1'b1;
          pc_req_o.sel         = PC_EXCEPTION;
          pc_req_o.exc_sel     = EXC_PC_ILLINSN;
          pc_req_o.exc_cause   = EXC_CAUSE_ILLEGAL_INSN;
          csr_req_o.cause      = EXC_CAUSE_ILLEGAL_INSN;
          csr_req_o.save_id    = 1'b1;
          csr_req_o.save_cause = 1'b1;
        end else if (insn_q.is_mret) begin
          pc_req_o.set           = 1'b1;
          pc_req_o.sel           = PC_ERET;
          csr_req_o.restore_mret = 1'b1;
        end else if (insn_q.is_ebreak) begin
          // cause only, no redirect without a debug unit
          pc_req_o.exc_cause = EXC_CAUSE_BREAKPOINT;
        end
        // a plain pipe flush orders nothing
      end

      default: begin
      end
    endcase
  end

endmodule

// File: verilog/perf_counter.sv
`timescale 1ns/1ps

module perf_counter #(
  parameter int unsigned PERF_CNT_W = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // events, one per cycle each
  input  logic                   jump_fire_i,
  input  ctrl_pkg::perf_events_t events_i,
  input  logic                   clear_i,

  // counter values
  output logic [PERF_CNT_W-1:0]  jump_cnt_o,
  output logic [PERF_CNT_W-1:0]  jr_stall_cnt_o,
  output logic [PERF_CNT_W-1:0]  br_stall_cnt_o,
  output logic [PERF_CNT_W-1:0]  ld_stall_cnt_o
);

  localparam int unsigned N_CNT = 4;

  // index 3 jump, 2 jump stall, 1 branch stall, 0 load stall
  logic [N_CNT-1:0]      event_vec;
  logic [PERF_CNT_W-1:0] cnt_q [N_CNT];

  assign event_vec = {jump_fire_i, events_i.jump_stall, events_i.branch_stall,
                      events_i.load_stall};

  ////////////////////////////////////////
  // saturating counters
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (clear_i) begin
      // clear beats a same-cycle event
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        // hold at all ones
        if (event_vec[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign jump_cnt_o     = cnt_q[3];
  assign jr_stall_cnt_o = cnt_q[2];
  assign br_stall_cnt_o = cnt_q[1];
  assign ld_stall_cnt_o = cnt_q[0];

endmodule

// File: verilog/ctrl_top.sv
`timescale 1ns/1ps

module ctrl_top #(
  parameter int unsigned PERF_CNT_W = 16
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // core enable and instruction handshake
  input  logic                          fetch_enable_i,
  input  logic                          insn_valid_i,
  input  ctrl_pkg::ctrl_insn_t          insn_i,

  // interrupt controller and CSR enable
  input  logic                          irq_req_i,
  input  logic [ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                          m_ie_i,

  // performance events
  input  ctrl_pkg::perf_events_t        perf_events_i,
  input  logic                          perf_clear_i,

  // pipeline control
  output logic                          insn_ready_o,
  output logic                          busy_o,
  output logic                          instr_req_o,
  output logic                          halt_if_o,
  output logic                          irq_ack_o,

  // PC and CSR requests
  output ctrl_pkg::pc_req_t             pc_req_o,
  output ctrl_pkg::csr_req_t            csr_req_o,

  // counter values
  output logic [PERF_CNT_W-1:0]         jump_cnt_o,
  output logic [PERF_CNT_W-1:0]         jr_stall_cnt_o,
  output logic [PERF_CNT_W-1:0]         br_stall_cnt_o,
  output logic [PERF_CNT_W-1:0]         ld_stall_cnt_o
);

  import ctrl_pkg::*;

  // FSM to trap unit
  ctrl_action_e action;
  logic         capture;
  logic         irq_capture;
  // FSM to counters
  logic         jump_fire;

  ////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .insn_valid_i   (insn_valid_i),
    .insn_i         (insn_i),
    .irq_req_i      (irq_req_i),
    .m_ie_i         (m_ie_i),
    .insn_ready_o   (insn_ready_o),
    .busy_o         (busy_o),
    .instr_req_o    (instr_req_o),
    .halt_if_o      (halt_if_o),
    .action_o       (action),
    .capture_o      (capture),
    .irq_capture_o  (irq_capture),
    .jump_fire_o    (jump_fire)
  );

  ////////////////////////////////////////
  // trap and cause unit
  ////////////////////////////////////////

  trap_cause_gen u_trap_cause_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .action_i      (action),
    .capture_i     (capture),
    .insn_i        (insn_i),
    .irq_capture_i (irq_capture),
    .irq_id_i      (irq_id_i),
    .pc_req_o      (pc_req_o),
    .csr_req_o     (csr_req_o)
  );

  // save_if is raised only in the IRQ_TAKEN cycle
  assign irq_ack_o = csr_req_o.save_if;

  ////////////////////////////////////////
  // performance counters
  ////////////////////////////////////////

  perf_counter #(
    .PERF_CNT_W (PERF_CNT_W)
  ) u_perf_counter (
    .clk            (clk),
    .rst_n          (rst_n),
    .jump_fire_i    (jump_fire),
    .events_i       (perf_events_i),
    .clear_i        (perf_clear_i),
    .jump_cnt_o     (jump_cnt_o),
    .jr_stall_cnt_o (jr_stall_cnt_o),
    .br_stall_cnt_o (br_stall_cnt_o),
    .ld_stall_cnt_o (ld_stall_cnt_o)
  );

endmodule

// File: testbench/tb_ctrl_model.svh
`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

// model state, moved on once per cycle at the falling edge
ctrl_state_e           m_state;
ctrl_insn_t            m_insn;
logic [IRQ_ID_W-1:0]   m_irq_id;
// 0 jump, 1 jump stall, 2 branch stall, 3 load stall
logic [PERF_CNT_W-1:0] m_cnt [4];

// expected values for the cycle being checked
logic        exp_ready;
logic        exp_busy;
logic        exp_instr_req;
logic        exp_irq_ack;
pc_req_t     exp_pc;
csr_req_t    exp_csr;
logic        take_irq;
logic        consumed;
ctrl_state_e next_state;

// how often each scenario was reached
int n_boot  = 0;
int n_jump  = 0;
int n_trap  = 0;
int n_irq   = 0;
int n_sleep = 0;

function automatic logic is_trap_class(input ctrl_insn_t c);
  return c.is_ecall | c.is_illegal | c.is_mret | c.is_ebreak | c.is_flush;
endfunction

task automatic reset_model();
  m_state  = RESET;
  m_insn   = '0;
  m_irq_id = '0;
  for (int i = 0; i < 4; i++) begin
    m_cnt[i] = '0;
  end
endtask

// outputs for this cycle from model state and the inputs now applied
task automatic compute_expected();
  logic blocked;
  exp_ready     = 1'b0;
  exp_busy      = 1'b1;
  exp_instr_req = 1'b1;
  exp_irq_ack   = 1'b0;
  exp_pc        = '0;
  exp_csr       = '0;
  take_irq      = 1'b0;
  consumed      = 1'b0;
  next_state    = m_state;
  case (m_state)
    RESET: begin
      exp_busy      = 1'b0;
      exp_instr_req = 1'b0;
      if (fetch_enable_i) next_state = BOOT_SET;
    end
    BOOT_SET: begin
      exp_pc.set = 1'b1;
      exp_pc.sel = PC_BOOT;
      next_state = FIRST_FETCH;
    end
    WAIT_SLEEP, SLEEP: begin
      exp_busy      = 1'b0;
      exp_instr_req = 1'b0;
      if (m_state == WAIT_SLEEP) next_state = SLEEP;
      else if (fetch_enable_i || irq_req_i) next_state = FIRST_FETCH;
    end
    FIRST_FETCH: begin
      take_irq   = irq_req_i & m_ie_i;
      next_state = take_irq ? IRQ_TAKEN : DECODE;
    end
    DECODE: begin
      // these must finish before an interrupt is taken
      blocked = insn_valid_i & (is_trap_class(insn_i) | insn_i.is_jump |
                                insn_i.is_branch_taken | insn_i.multicycle);
      if (irq_req_i && m_ie_i && !blocked) begin
        take_irq   = 1'b1;
        next_state = IRQ_TAKEN;
      end else begin
        exp_ready = 1'b1;
        consumed  = insn_valid_i;
        if (consumed && (insn_i.is_jump || insn_i.is_branch_taken)) begin
          exp_pc.set = 1'b1;
          exp_pc.sel = PC_JUMP;
        end else if (consumed && is_trap_class(insn_i)) begin
          next_state = FLUSH;
        end
      end
    end
    FLUSH: begin
      next_state = fetch_enable_i ? DECODE : WAIT_SLEEP;
      // trap priority ecall > illegal > mret > ebreak > flush
      if (m_insn.is_ecall || m_insn.is_illegal) begin
        exp_pc.set          = 1'b1;
        exp_pc.sel          = PC_EXCEPTION;
        exp_pc.exc_sel      = m_insn.is_ecall ? EXC_PC_ECALL : EXC_PC_ILLINSN;
        exp_pc.exc_cause    = m_insn.is_ecall ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ILLEGAL_INSN;
        exp_csr.cause       = exp_pc.exc_cause;
        exp_csr.save_id     = 1'b1;
        exp_csr.save_cause  = 1'b1;
      end else if (m_insn.is_mret) begin
        exp_pc.set           = 1'b1;
        exp_pc.sel           = PC_ERET;
        exp_csr.restore_mret = 1'b1;
      end else if (m_insn.is_ebreak) begin
        exp_pc.exc_cause = EXC_CAUSE_BREAKPOINT;
      end
    end
    IRQ_TAKEN: begin
      exp_irq_ack        = 1'b1;
      exp_pc.set         = 1'b1;
      exp_pc.sel         = PC_EXCEPTION;
      exp_pc.exc_sel     = EXC_PC_IRQ;
      exp_pc.exc_cause   = {1'b0, m_irq_id};
      exp_csr.cause      = {1'b1, m_irq_id};
      exp_csr.save_if    = 1'b1;
      exp_csr.save_cause = 1'b1;
      next_state         = DECODE;
    end
    default: next_state = RESET;
  endcase
endtask

// state, captures and counters as they stand after the next edge
task automatic advance_model();
  logic [3:0] ev;
  ev = {perf_events_i.load_stall, perf_events_i.branch_stall,
        perf_events_i.jump_stall, consumed & insn_i.is_jump};
  if (!rst_n) begin
    reset_model();
  end else begin
    if (m_state == BOOT_SET) n_boot++;
    if (m_state == FLUSH) n_trap++;
    if (m_state == IRQ_TAKEN) n_irq++;
    if (m_state == WAIT_SLEEP) n_sleep++;
    if (exp_pc.sel == PC_JUMP && exp_pc.set) n_jump++;
    if (m_state == DECODE && next_state == FLUSH) m_insn = insn_i;
    if (take_irq) m_irq_id = irq_id_i;
    for (int i = 0; i < 4; i++) begin
      // clear wins, then hold at all ones
      if (perf_clear_i) m_cnt[i] = '0;
      else if (ev[i] && m_cnt[i] != '1) m_cnt[i] = m_cnt[i] + PERF_CNT_W'(1);
    end
    m_state = next_state;
  end
endtask

`endif

// File: testbench/tb_ctrl_top.sv
`timescale 1ns/1ps

module tb_ctrl_top #(
  parameter int unsigned PERF_CNT_W = 16
);

  import ctrl_pkg::*;

  localparam int          TEST_CYCLES    = 3000;
  localparam int          TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 3;
  localparam logic [31:0] SEED           = 32'h87b7_32ff;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  fetch_enable_i;
  logic                  insn_valid_i;
  ctrl_insn_t            insn_i;
  logic                  irq_req_i;
  logic [IRQ_ID_W-1:0]   irq_id_i;
  logic                  m_ie_i;
  perf_events_t          perf_events_i;
  logic                  perf_clear_i;
  logic                  insn_ready_o;
  logic                  busy_o;
  logic                  instr_req_o;
  logic                  halt_if_o;
  logic                  irq_ack_o;
  pc_req_t               pc_req_o;
  csr_req_t              csr_req_o;
  logic [PERF_CNT_W-1:0] jump_cnt_o;
  logic [PERF_CNT_W-1:0] jr_stall_cnt_o;
  logic [PERF_CNT_W-1:0] br_stall_cnt_o;
  logic [PERF_CNT_W-1:0] ld_stall_cnt_o;

  logic [31:0] seed      = SEED;
  // valid and not ready last cycle, so insn_i must stay
  logic        hold_insn = 1'b0;
  int          n_errors  = 0;
  int          n_checks  = 0;
  int          cycle_cnt = 0;

  `include "tb_ctrl_model.svh"

  ctrl_top #(.PERF_CNT_W(PERF_CNT_W)) u_ctrl_top (.*);

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // plain, jump, branch, multicycle, one trap flag or several at once
  function automatic ctrl_insn_t pick_insn(input logic [31:0] r);
    ctrl_insn_t c;
    c = '0;
    case (r[2:0])
      3'd3: c.is_jump = 1'b1;
      3'd4: c.is_branch_taken = 1'b1;
      3'd5: begin
        {c.is_ecall, c.is_illegal, c.is_mret, c.is_ebreak, c.is_flush} = r[7:3];
        if (r[7:3] == 5'd0) c.is_flush = 1'b1;
      end
      3'd6: c.multicycle = 1'b1;
      3'd7: begin
        case (r[5:3])
          3'd0: c.is_ecall = 1'b1;
          3'd1: c.is_illegal = 1'b1;
          3'd2: c.is_mret = 1'b1;
          3'd3: c.is_ebreak = 1'b1;
          default: c.is_flush = 1'b1;
        endcase
      end
      default: c = '0;
    endcase
    return c;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    n_errors++;
    $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
  endtask

  task automatic drive_random();
    seed = xorshift32(seed);
    fetch_enable_i <= (seed[2:0] != 3'd0);
    irq_req_i      <= (seed[5:3] == 3'd0);
    m_ie_i         <= (seed[7:6] != 2'b00);
    irq_id_i       <= seed[12:8];
    // each stall bit about one cycle in four
    perf_events_i  <= perf_events_t'(seed[15:13] & seed[18:16]);
    perf_clear_i   <= (seed[24:19] == 6'd0);
    if (!hold_insn) begin
      seed = xorshift32(seed);
      insn_valid_i <= (seed[1:0] != 2'b00);
      insn_i       <= pick_insn(seed >> 2);
    end
  endtask

  task automatic compare_outputs();
    n_checks++;
    if (insn_ready_o !== exp_ready)
      report_mismatch("insn_ready_o", 32'(insn_ready_o), 32'(exp_ready));
    if (busy_o !== exp_busy)
      report_mismatch("busy_o", 32'(busy_o), 32'(exp_busy));
    if (instr_req_o !== exp_instr_req)
      report_mismatch("instr_req_o", 32'(instr_req_o), 32'(exp_instr_req));
    if (irq_ack_o !== exp_irq_ack)
      report_mismatch("irq_ack_o", 32'(irq_ack_o), 32'(exp_irq_ack));
    if (take_irq && halt_if_o !== 1'b1)
      report_mismatch("halt_if_o", 32'(halt_if_o), 32'd1);
    // fetch is not halted while waiting for the first enable
    if (m_state == RESET && halt_if_o !== 1'b0)
      report_mismatch("halt_if_o", 32'(halt_if_o), 32'd0);
    if (pc_req_o !== exp_pc)
      report_mismatch("pc_req_o", 32'(pc_req_o), 32'(exp_pc));
    if (csr_req_o !== exp_csr)
      report_mismatch("csr_req_o", 32'(csr_req_o), 32'(exp_csr));
    if (jump_cnt_o !== m_cnt[0])
      report_mismatch("jump_cnt_o", 32'(jump_cnt_o), 32'(m_cnt[0]));
    if (jr_stall_cnt_o !== m_cnt[1])
      report_mismatch("jr_stall_cnt_o", 32'(jr_stall_cnt_o), 32'(m_cnt[1]));
    if (br_stall_cnt_o !== m_cnt[2])
      report_mismatch("br_stall_cnt_o", 32'(br_stall_cnt_o), 32'(m_cnt[2]));
    if (ld_stall_cnt_o !== m_cnt[3])
      report_mismatch("ld_stall_cnt_o", 32'(ld_stall_cnt_o), 32'(m_cnt[3]));
  endtask

  ////////////////////////////////////////
  // clock, checks and watchdog
  ////////////////////////////////////////

  initial begin
    forever #5 clk = ~clk;
  end

  // compare midway between input updates, then step the model
  always @(negedge clk) begin
    compute_expected();
    compare_outputs();
    hold_insn = insn_valid_i & ~insn_ready_o;
    advance_model();
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the test did not reach its end", cycle_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    reset_model();
    rst_n          <= 1'b0;
    fetch_enable_i <= 1'b0;
    insn_valid_i   <= 1'b0;
    insn_i         <= '0;
    irq_req_i      <= 1'b0;
    irq_id_i       <= '0;
    m_ie_i         <= 1'b0;
    perf_events_i  <= '0;
    perf_clear_i   <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < TEST_CYCLES; i++) begin
      @(posedge clk);
      drive_random();
    end
    @(negedge clk);
    #1;
    // every scenario has to show up at least once
    if (n_boot == 0 || n_jump == 0 || n_trap == 0 || n_irq == 0 || n_sleep == 0) begin
      n_errors++;
      $display("not every scenario was reached by the random stimulus");
    end
    $display("checks=%0d errors=%0d boots=%0d jumps=%0d traps=%0d irqs=%0d sleeps=%0d",
             n_checks, n_errors, n_boot, n_jump, n_trap, n_irq, n_sleep);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+testbench
verilog/ctrl_pkg.sv
verilog/ctrl_fsm.sv
verilog/trap_cause_gen.sv
verilog/perf_counter.sv
verilog/ctrl_top.sv
testbench/tb_ctrl_top.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_ctrl_top
RTL_TOP    ?= ctrl_top
FILELIST   ?= sources.f
PERF_CNT_W ?= 4
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
PASS_MSG   := PASS: all tests
RTL_SRCS   := $(filter verilog/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GPERF_CNT_W=$(PERF_CNT_W) \
	  -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -GPERF_CNT_W=$(PERF_CNT_W) \
	  -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
